/* Makefile */
SIM  := obj_dir/Vtb_mcu_top
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

$(SIM): $(SRCS) flist.f
	verilator --binary --timing --assert -j 0 --top-module tb_mcu_top -f flist.f

clean:
	rm -rf obj_dir

/* flist.f */
hw/mcu_pkg.sv
hw/wb_bus_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_bridge.sv
hw/demo_io.sv
hw/mcu_top.sv
verification/tb_mcu_top.sv

/* hw/cmd_bridge.sv */
// ======================================================================
// Serial command parser and bus master that runs one bus cycle per command
// ======================================================================
module cmd_bridge (
  input  logic       clk,
  input  logic       reset_i,
  input  logic [7:0] rx_data_i,
  input  logic       rx_valid_i,
  output logic       rx_ready_o,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o,
  input  logic       tx_ready_i,
  wb_bus_if.master   bus
);

  typedef enum logic [2:0] {
    ST_CMD,
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_DATA,
    ST_BUS,
    ST_REPLY
  } br_state_t;

  localparam int AW = mcu_pkg::ADDR_W;
  localparam int DW = mcu_pkg::DATA_W;

  br_state_t         state;
  logic              is_write;
  logic [1:0]        byte_cnt;   // Write data bytes received
  logic [2:0]        rsp_left;   // Reply bytes still to send
  logic [AW-1:0]     adr_q;
  logic [DW-1:0]     dat_q;
  logic [DW-1:0]     rsp_q;      // Reply shifts out MSB first
  logic              rx_fire;
  logic              tx_fire;

  assign rx_ready_o = (state == ST_CMD) || (state == ST_ADDR_HI) ||
                      (state == ST_ADDR_LO) || (state == ST_DATA);
  assign rx_fire    = rx_valid_i && rx_ready_o;
  assign tx_valid_o = (state == ST_REPLY);
  assign tx_data_o  = rsp_q[DW-1 -: 8];
  assign tx_fire    = tx_valid_o && tx_ready_i;

  // Bus signals come straight from the holding registers
  assign bus.adr   = adr_q;
  assign bus.dat_w = dat_q;
  assign bus.we    = is_write;
  assign bus.stb   = (state == ST_BUS);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state    <= ST_CMD;
      is_write <= 1'b0;
      byte_cnt <= '0;
      rsp_left <= '0;
    end else begin
      case (state)
        ST_CMD: begin
          if (rx_fire) begin
            is_write <= (rx_data_i == mcu_pkg::CMD_WRITE);
            if (rx_data_i == mcu_pkg::CMD_WRITE || rx_data_i == mcu_pkg::CMD_READ) begin
              state <= ST_ADDR_HI;
            end else begin
              rsp_left <= 3'd1;  // Unknown command gets only the error byte
              state    <= ST_REPLY;
            end
          end
        end
        ST_ADDR_HI: if (rx_fire) state <= ST_ADDR_LO;
        ST_ADDR_LO: begin
          if (rx_fire) begin
            byte_cnt <= '0;
            state    <= is_write ? ST_DATA : ST_BUS;
          end
        end
        ST_DATA: begin
          if (rx_fire) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) state <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (bus.ack) begin
            rsp_left <= is_write ? 3'd1 : 3'd4;
            state    <= ST_REPLY;   // stb drops next cycle
          end
        end
        ST_REPLY: begin
          if (tx_fire) begin
            rsp_left <= rsp_left - 1'b1;
            if (rsp_left == 3'd1) state <= ST_CMD;
          end
        end
        default: state <= ST_CMD;
      endcase
    end
  end

  // Address, data and reply registers
  always_ff @(posedge clk) begin
    if (state == ST_CMD && rx_fire) rsp_q <= {mcu_pkg::RSP_ERR, {(DW-8){1'b0}}};
    // Top bit of the high byte is dropped
    if (state == ST_ADDR_HI && rx_fire) adr_q[AW-1:8] <= rx_data_i[AW-9:0];
    if (state == ST_ADDR_LO && rx_fire) adr_q[7:0] <= rx_data_i;
    if (state == ST_DATA && rx_fire) dat_q <= {dat_q[DW-9:0], rx_data_i};
    if (state == ST_BUS && bus.ack) begin
      rsp_q <= is_write ? {mcu_pkg::RSP_ACK, {(DW-8){1'b0}}} : bus.dat_r;
    end
    if (tx_fire) rsp_q <= {rsp_q[DW-9:0], 8'h00};
  end

  a_bus_ack: assert property (@(posedge clk) disable iff (reset_i)
    bus.stb && !bus.ack |=> bus.ack)
    else $error("cmd_bridge: bus cycle not acknowledged in time");

  a_rx_quiet: assert property (@(posedge clk) disable iff (reset_i)
    !rx_ready_o |-> !rx_valid_i)
    else $error("cmd_bridge: command byte arrived while busy");

endmodule

/* hw/demo_io.sv */
// ======================================================================
// Bus slave with LED output, switch input and a scratch register
// ======================================================================
module demo_io (
  input  logic       clk,
  input  logic       reset_i,
  wb_bus_if.slave    bus,
  output logic [7:0] gp_o,
  input  logic [7:0] gp_i
);

  logic                       ack_q;
  logic                       access;     // First cycle of a strobe
  logic [7:0]                 gpi_meta;
  logic [7:0]                 gpi_sync;
  logic [mcu_pkg::DATA_W-1:0] scratch_q;
  logic [mcu_pkg::DATA_W-1:0] rdata_q;

  assign access    = bus.stb && !ack_q;
  assign bus.ack   = ack_q;
  assign bus.dat_r = rdata_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      gp_o  <= '0;   // LEDs off after reset
    end else begin
      ack_q <= access;
      if (access && bus.we && bus.adr == mcu_pkg::ADDR_GPO) gp_o <= bus.dat_w[7:0];
    end
  end

  // Switches are asynchronous to clk
  always_ff @(posedge clk) begin
    gpi_meta <= gp_i;
    gpi_sync <= gpi_meta;
  end

  always_ff @(posedge clk) begin
    if (access && bus.we && bus.adr == mcu_pkg::ADDR_SCRATCH) scratch_q <= bus.dat_w;
    if (access) begin
      case (bus.adr)
        mcu_pkg::ADDR_GPO:     rdata_q <= {{(mcu_pkg::DATA_W-8){1'b0}}, gp_o};
        mcu_pkg::ADDR_GPI:     rdata_q <= {{(mcu_pkg::DATA_W-8){1'b0}}, gpi_sync};
        mcu_pkg::ADDR_SCRATCH: rdata_q <= scratch_q;
        default:               rdata_q <= '0;  // Unmapped reads as zero
      endcase
    end
  end

  a_stb_drop: assert property (@(posedge clk) disable iff (reset_i)
    bus.ack |=> !bus.stb)
    else $error("demo_io: strobe still high after ack");

endmodule

/* hw/mcu_pkg.sv */
// ======================================================================
// Shared MCU constants for bus widths, serial timing, commands and map
// ======================================================================
package mcu_pkg;

  // Internal bus
  localparam int ADDR_W = 15;   // Word address width
  localparam int DATA_W = 32;

  // Serial port timing
  localparam int BAUD_DIV   = 16;  // Clocks per serial bit
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

  // Bit counter compare points
  localparam logic [BAUD_CNT_W-1:0] BIT_END  = BAUD_CNT_W'(BAUD_DIV - 1);
  localparam logic [BAUD_CNT_W-1:0] HALF_BIT = BAUD_CNT_W'(BAUD_DIV / 2 - 1);

  // Host command bytes
  localparam logic [7:0] CMD_WRITE = 8'h57;  // 'W'
  localparam logic [7:0] CMD_READ  = 8'h52;  // 'R'

  // Reply bytes
  localparam logic [7:0] RSP_ACK = 8'h4B;  // 'K'
  localparam logic [7:0] RSP_ERR = 8'h3F;  // '?'

  // Register map in word addresses
  localparam logic [ADDR_W-1:0] ADDR_GPO     = ADDR_W'(0);  // LED register
  localparam logic [ADDR_W-1:0] ADDR_GPI     = ADDR_W'(1);  // Read-only switches
  localparam logic [ADDR_W-1:0] ADDR_SCRATCH = ADDR_W'(2);

endpackage

/* hw/mcu_top.sv */
// ======================================================================
// MCU top: reset sync, serial command bridge, I/O block, active-low LEDs
// ======================================================================
module mcu_top (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       uart_rx_i,
  output logic       uart_tx_o,
  output logic [7:0] led_o,
  input  logic [7:0] sw_i
);

  logic       rst_meta;
  logic       rst_sync;   // Internal reset
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_ready;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] gp_out;

  // Two-stage reset synchronizer
  always_ff @(posedge clk) begin
    rst_meta <= reset_i;
    rst_sync <= rst_meta;
  end

  wb_bus_if bus ();

  uart_rx u_uart_rx (
    .clk     (clk),
    .reset_i (rst_sync),
    .rxd_i   (uart_rx_i),
    .data_o  (rx_data),
    .valid_o (rx_valid),
    .ready_i (rx_ready)
  );

  cmd_bridge u_cmd_bridge (
    .clk        (clk),
    .reset_i    (rst_sync),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .rx_ready_o (rx_ready),
    .tx_data_o  (tx_data),
    .tx_valid_o (tx_valid),
    .tx_ready_i (tx_ready),
    .bus        (bus.master)
  );

  uart_tx u_uart_tx (
    .clk     (clk),
    .reset_i (rst_sync),
    .data_i  (tx_data),
    .valid_i (tx_valid),
    .ready_o (tx_ready),
    .txd_o   (uart_tx_o)
  );

  demo_io u_demo_io (
    .clk     (clk),
    .reset_i (rst_sync),
    .bus     (bus.slave),
    .gp_o    (gp_out),
    .gp_i    (sw_i)
  );

  assign led_o = ~gp_out;  // LEDs are active low

endmodule

/* hw/uart_rx.sv */
// ======================================================================
// UART receiver, 8N1 serial in, bytes out on a valid/ready stream
// ======================================================================
module uart_rx (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       rxd_i,
  output logic [7:0] data_o,
  output logic       valid_o,
  input  logic       ready_i
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t                         state;
  logic [1:0]                        rxd_sync;
  logic                              rxd_s;
  logic [mcu_pkg::BAUD_CNT_W-1:0]    cnt;
  logic [2:0]                        bit_idx;
  logic [7:0]                        shift_q;
  logic                              bit_end;

  assign rxd_s   = rxd_sync[1];
  assign bit_end = (cnt == mcu_pkg::BIT_END);

  // Line synchronizer, idles high
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd_i};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      valid_o <= 1'b0;
    end else begin
      if (valid_o && ready_i) valid_o <= 1'b0;  // Byte taken
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rxd_s) state <= RX_START;
        end
        RX_START: begin
          // Recheck line at middle of start bit
          if (cnt == mcu_pkg::HALF_BIT) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_s ? RX_IDLE : RX_DATA;  // Glitch, back to idle
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 3'd7) state <= RX_STOP;
            bit_idx <= bit_idx + 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= RX_IDLE;
            if (rxd_s) valid_o <= 1'b1;  // Framing error drops the byte
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Payload path, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) shift_q <= {rxd_s, shift_q[7:1]};
    if (state == RX_STOP && bit_end && rxd_s) data_o <= shift_q;
  end

  a_rx_hold: assert property (@(posedge clk) disable iff (reset_i)
    valid_o && !ready_i |=> $stable(data_o))
    else $error("uart_rx: byte changed while waiting for consumer");

endmodule

/* hw/uart_tx.sv */
// ======================================================================
// UART transmitter, valid/ready bytes in, 8N1 serial out
// ======================================================================
module uart_tx (
  input  logic       clk,
  input  logic       reset_i,
  input  logic [7:0] data_i,
  input  logic       valid_i,
  output logic       ready_o,
  output logic       txd_o
);

  logic                           busy;
  logic [mcu_pkg::BAUD_CNT_W-1:0] cnt;
  logic [3:0]                     bit_cnt;  // Counts 10 frame bits
  logic [9:0]                     frame_q;
  logic                           load;
  logic                           bit_end;

  assign ready_o = ~busy;
  assign load    = valid_i && ready_o;
  assign bit_end = busy && (cnt == mcu_pkg::BIT_END);
  assign txd_o   = busy ? frame_q[0] : 1'b1;  // Idle high

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy    <= 1'b0;
      cnt     <= '0;
      bit_cnt <= '0;
    end else if (load) begin
      busy    <= 1'b1;
      cnt     <= '0;
      bit_cnt <= '0;
    end else if (busy) begin
      if (bit_end) begin
        cnt <= '0;
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;  // Stop bit done
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Frame is stop, data, start, shifted out from bit 0
  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= {1'b1, data_i, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

endmodule

/* hw/wb_bus_if.sv */
// ======================================================================
// Single-master internal bus, classic strobe/ack handshake
// ======================================================================
interface wb_bus_if;

  logic [mcu_pkg::ADDR_W-1:0] adr;
  logic [mcu_pkg::DATA_W-1:0] dat_w;   // Master to slave
  logic [mcu_pkg::DATA_W-1:0] dat_r;   // Slave to master
  logic                       we;
  logic                       stb;
  logic                       ack;

  // Master holds adr, dat_w, we and stb until ack
  modport master (
    output adr,
    output dat_w,
    output we,
    output stb,
    input  dat_r,
    input  ack
  );

  // One-cycle ack with read data
  modport slave (
    input  adr,
    input  dat_w,
    input  we,
    input  stb,
    output dat_r,
    output ack
  );

endinterface

/* verification/mcu_cases.txt */
# op addr data sw expected_reply, all hex; W write, R read, X raw command byte in data
# writes reply 0000004B, unknown bytes 0000003F, reads the 32-bit word
W 0000 000000A5 00 0000004B
R 0000 00000000 00 000000A5
R 0001 00000000 3C 0000003C
R 0001 00000000 C3 000000C3
W 0002 DEADBEEF 00 0000004B
R 0002 00000000 00 DEADBEEF
R 0123 00000000 00 00000000
W 0123 12345678 00 0000004B
R 0123 00000000 00 00000000
X 0000 00000041 00 0000003F
R 0002 00000000 5A DEADBEEF
W 8000 0000005A 00 0000004B
R 0000 00000000 00 0000005A
X 0000 000000FF 00 0000003F
W 0000 0000FF0F 00 0000004B
R 0000 00000000 00 0000000F
W 0001 FFFFFFFF 81 0000004B
R 0001 00000000 81 00000081

/* verification/tb_mcu_top.sv */
// ======================================================================
// Testbench for mcu_top: serial host that runs cases from a data file
// ======================================================================
module tb_mcu_top;

  logic       clk;
  logic       reset_i;
  logic       uart_rx_i;
  logic       uart_tx_o;
  logic [7:0] led_o;
  logic [7:0] sw_i;

  // Cases from the data file
  logic [7:0]  op_q[$];
  logic [31:0] adr_q[$];
  logic [31:0] dat_q[$];
  logic [31:0] sw_q[$];
  logic [31:0] exp_q[$];

  logic [7:0] led_exp;     // Expected LED pins, active low
  int         case_idx;
  int         cycle_cnt;
  int         cycle_limit;

  mcu_top dut (
    .clk       (clk),
    .reset_i   (reset_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .led_o     (led_o),
    .sw_i      (sw_i)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at time %0t: case %0d, %s got %h, expected %h",
                          $time, case_idx, what, got, exp));
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout: no complete reply in case %0d after %0d cycles",
                          case_idx, cycle_cnt));
    end
  end

  task automatic read_cases();
    int             fd;
    int             r;
    logic [7:0]     op;
    logic [31:0]    a, d, s, e;
    logic [1023:0]  skip;
    fd = $fopen("verification/mcu_cases.txt", "r");
    if (fd == 0) abort_run("Cannot open case file verification/mcu_cases.txt");
    while (1) begin
      r = $fscanf(fd, " %c", op);
      if (r != 1) break;
      if (op == "#") begin
        void'($fgets(skip, fd));  // Comment line
      end else begin
        r = $fscanf(fd, "%h %h %h %h", a, d, s, e);
        if (r != 4) abort_run("Case file has a line with missing columns");
        op_q.push_back(op);
        adr_q.push_back(a);
        dat_q.push_back(d);
        sw_q.push_back(s);
        exp_q.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // 8N1 frame onto the DUT's receive pin, LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx_i = frame[i];
      repeat (mcu_pkg::BAUD_DIV) @(posedge clk);
      #1;
    end
  endtask

  task automatic recv_byte(output logic [7:0] b);
    b = 8'h00;
    @(negedge clk);
    while (uart_tx_o !== 1'b0) @(negedge clk);
    repeat (mcu_pkg::BAUD_DIV / 2) @(negedge clk);  // Middle of start bit
    check_value(32'(uart_tx_o), 32'd0, "reply start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (mcu_pkg::BAUD_DIV) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (mcu_pkg::BAUD_DIV) @(negedge clk);
    check_value(32'(uart_tx_o), 32'd1, "reply stop bit");
  endtask

  // Reply bytes arrive MSB first
  task automatic recv_reply(input int n, output logic [31:0] word);
    logic [7:0] b;
    word = 32'h0;
    for (int i = 0; i < n; i++) begin
      recv_byte(b);
      word = {word[23:0], b};
    end
  endtask

  task automatic run_case(input int i);
    logic [7:0]  bytes[$];
    logic [31:0] got;
    int          nrsp;
    case_idx = i + 1;
    nrsp = 1;
    if (op_q[i] == "W" || op_q[i] == "R") begin
      bytes.push_back(op_q[i] == "W" ? mcu_pkg::CMD_WRITE : mcu_pkg::CMD_READ);
      bytes.push_back(adr_q[i][15:8]);
      bytes.push_back(adr_q[i][7:0]);
      if (op_q[i] == "W") begin
        for (int k = 3; k >= 0; k--) bytes.push_back(dat_q[i][8*k +: 8]);
        // Address top bit is dropped by the bridge
        if (adr_q[i][14:0] == mcu_pkg::ADDR_GPO) led_exp = ~dat_q[i][7:0];
      end else begin
        nrsp = 4;
      end
    end else if (op_q[i] == "X") begin
      bytes.push_back(dat_q[i][7:0]);   // Raw command byte
    end else begin
      abort_run($sformatf("Unknown operation in case %0d of the case file", i + 1));
    end
    @(posedge clk);
    #1;
    sw_i = sw_q[i][7:0];
    fork
      begin
        foreach (bytes[k]) send_byte(bytes[k]);
      end
      recv_reply(nrsp, got);
    join
    check_value(got, exp_q[i], "reply");
    check_value(32'(led_o), 32'(led_exp), "LED pins");
  endtask

  initial begin
    reset_i     = 1'b1;
    uart_rx_i   = 1'b1;   // Line idle
    sw_i        = 8'h00;
    case_idx    = 0;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    read_cases();
    if (op_q.size() == 0) abort_run("Case file holds no test cases");
    cycle_limit = op_q.size() * 8 * 10 * mcu_pkg::BAUD_DIV * 2 + 200;
    repeat (10) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // Quiet after reset, LEDs off
    led_exp = 8'hFF;
    repeat (4 * mcu_pkg::BAUD_DIV) begin
      @(negedge clk);
      check_value(32'(uart_tx_o), 32'd1, "idle serial line");
    end
    check_value(32'(led_o), 32'(led_exp), "LED pins after reset");

    for (int i = 0; i < op_q.size(); i++) run_case(i);

    $display("Simulation passed");
    $finish;
  end

endmodule
